/* Makefile */
# Verilator build and run of the tagged cache queue testbench

VERILATOR ?= verilator
TOP       ?= tag_cache_fifo_tb
FILELIST  ?= tag_cache_fifo.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= No errors
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

SOURCES := $(wildcard hdl/*.sv verification/*.sv verification/*.svh)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, search the log for the pass text"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_TEXT VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/read_result_stats.sv */
// Registered read result, completion pulse, hit and miss counters and hit ratio
`timescale 1ns/1ps

module read_result_stats
    import tag_cache_pkg::*;
#(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pop,
    input  lookup_result_e        result,
    input  logic [DATA_WIDTH-1:0] result_data,
    input  logic                  clear_stats,
    output logic [DATA_WIDTH-1:0] rd_data,
    output logic                  rd_hit,
    output logic                  rd_done,
    output logic [STAT_WIDTH-1:0] cache_hits,
    output logic [STAT_WIDTH-1:0] cache_misses,
    output logic [STAT_WIDTH-1:0] hit_ratio
);

    localparam int WIDE = 2 * STAT_WIDTH;

    logic            is_hit;
    logic [STAT_WIDTH:0] stat_total;
    logic [WIDE-1:0] scaled_hits;
    logic [WIDE-1:0] ratio_full;

    assign is_hit = (result == LOOKUP_CACHE_HIT);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
            rd_hit  <= 1'b0;
            rd_done <= 1'b0;
        end else begin
            rd_done <= pop;
            if (pop) begin
                rd_data <= result_data;
                rd_hit  <= is_hit;
            end
        end
    end

    // Clear wins over an increment on the same edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cache_hits   <= '0;
            cache_misses <= '0;
        end else if (clear_stats) begin
            cache_hits   <= '0;
            cache_misses <= '0;
        end else if (pop) begin
            if (is_hit) begin
                cache_hits <= cache_hits + 1'b1;
            end else begin
                cache_misses <= cache_misses + 1'b1;
            end
        end
    end

    // Double width product so large hit counts do not wrap
    assign stat_total  = {1'b0, cache_hits} + {1'b0, cache_misses};
    assign scaled_hits = WIDE'(cache_hits) * WIDE'(RATIO_SCALE);
    assign ratio_full  = (stat_total == '0) ? '0 : scaled_hits / WIDE'(stat_total);
    assign hit_ratio   = ratio_full[STAT_WIDTH-1:0];

    a_done_from_pops: assert property (
        @(posedge clk) disable iff (!rst_n)
        (rd_done && $past(rd_done)) |-> ($past(pop) && $past(pop, 2))
    );

endmodule

/* hdl/tag_cache_fifo_top.sv */
// Top level of the tagged cache queue: tag store, cache lookup and result statistics
`timescale 1ns/1ps

module tag_cache_fifo_top
    import tag_cache_pkg::*;
#(
    parameter int DATA_WIDTH    = 32,
    parameter int TAG_WIDTH     = 8,
    parameter int ADDR_WIDTH    = 4,
    parameter int CACHE_ENTRIES = 4,
    parameter int USE_LRU       = 1
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_en,
    input  logic [DATA_WIDTH-1:0] wr_data,
    input  logic [TAG_WIDTH-1:0]  wr_tag,
    input  logic                  rd_en,
    input  logic [TAG_WIDTH-1:0]  rd_tag,
    input  logic                  clear_stats,
    output logic                  wr_ready,
    output logic                  full,
    output logic                  empty,
    output logic                  rd_valid,
    output logic [ADDR_WIDTH:0]   data_count,
    output logic [DATA_WIDTH-1:0] rd_data,
    output logic                  rd_hit,
    output logic                  rd_done,
    output logic [STAT_WIDTH-1:0] cache_hits,
    output logic [STAT_WIDTH-1:0] cache_misses,
    output logic [STAT_WIDTH-1:0] hit_ratio
);

    logic                  pop;
    logic                  match_found;
    logic [DATA_WIDTH-1:0] match_data;
    logic [DATA_WIDTH-1:0] head_data;
    lookup_result_e        result;
    logic [DATA_WIDTH-1:0] result_data;

    // Input side
    tag_store_fifo #(
        .DATA_WIDTH (DATA_WIDTH),
        .TAG_WIDTH  (TAG_WIDTH),
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_store (
        .clk         (clk),
        .rst_n       (rst_n),
        .wr_en       (wr_en),
        .wr_data     (wr_data),
        .wr_tag      (wr_tag),
        .rd_en       (rd_en),
        .rd_tag      (rd_tag),
        .wr_ready    (wr_ready),
        .full        (full),
        .empty       (empty),
        .rd_valid    (rd_valid),
        .data_count  (data_count),
        .pop         (pop),
        .match_found (match_found),
        .match_data  (match_data),
        .head_data   (head_data)
    );

    tag_cache_lookup #(
        .DATA_WIDTH    (DATA_WIDTH),
        .TAG_WIDTH     (TAG_WIDTH),
        .CACHE_ENTRIES (CACHE_ENTRIES),
        .USE_LRU       (USE_LRU)
    ) u_lookup (
        .clk         (clk),
        .rst_n       (rst_n),
        .pop         (pop),
        .rd_tag      (rd_tag),
        .match_found (match_found),
        .match_data  (match_data),
        .head_data   (head_data),
        .result      (result),
        .result_data (result_data)
    );

    // Output side
    read_result_stats #(
        .DATA_WIDTH (DATA_WIDTH)
    ) u_stats (
        .clk          (clk),
        .rst_n        (rst_n),
        .pop          (pop),
        .result       (result),
        .result_data  (result_data),
        .clear_stats  (clear_stats),
        .rd_data      (rd_data),
        .rd_hit       (rd_hit),
        .rd_done      (rd_done),
        .cache_hits   (cache_hits),
        .cache_misses (cache_misses),
        .hit_ratio    (hit_ratio)
    );

endmodule

/* hdl/tag_cache_lookup.sv */
// Fully associative tag cache with LRU or round robin replacement and outcome decision
`timescale 1ns/1ps

module tag_cache_lookup
    import tag_cache_pkg::*;
#(
    parameter int DATA_WIDTH    = 32,
    parameter int TAG_WIDTH     = 8,
    parameter int CACHE_ENTRIES = 4,
    parameter int USE_LRU       = 1
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pop,
    input  logic [TAG_WIDTH-1:0]  rd_tag,
    input  logic                  match_found,
    input  logic [DATA_WIDTH-1:0] match_data,
    input  logic [DATA_WIDTH-1:0] head_data,
    output lookup_result_e        result,
    output logic [DATA_WIDTH-1:0] result_data
);

    localparam int IDX_W = $clog2(CACHE_ENTRIES);

    logic [TAG_WIDTH-1:0]     cache_tag  [CACHE_ENTRIES];
    logic [DATA_WIDTH-1:0]    cache_data [CACHE_ENTRIES];
    logic [CACHE_ENTRIES-1:0] cache_valid;
    // Rank 0 is most recent, CACHE_ENTRIES-1 is the LRU victim
    logic [IDX_W-1:0]         age_rank   [CACHE_ENTRIES];
    logic [IDX_W-1:0]         rr_ptr;

    logic [CACHE_ENTRIES-1:0] hit_vec;
    logic                     cache_hit;
    logic [IDX_W-1:0]         hit_idx;
    logic                     has_free;
    logic [IDX_W-1:0]         free_idx;
    logic [IDX_W-1:0]         lru_idx;
    logic [IDX_W-1:0]         fill_idx;
    logic                     fill_en;
    logic                     touch_en;
    logic [IDX_W-1:0]         touch_idx;

    always_comb begin
        hit_idx = '0;
        for (int k = 0; k < CACHE_ENTRIES; k++) begin
            hit_vec[k] = cache_valid[k] && (cache_tag[k] == rd_tag);
        end
        for (int k = CACHE_ENTRIES - 1; k >= 0; k--) begin
            if (hit_vec[k]) begin
                hit_idx = IDX_W'(k);
            end
        end
    end

    assign cache_hit = |hit_vec;

    // Lowest free slot first, then the policy victim
    always_comb begin
        has_free = 1'b0;
        free_idx = '0;
        lru_idx  = '0;
        for (int k = CACHE_ENTRIES - 1; k >= 0; k--) begin
            if (!cache_valid[k]) begin
                has_free = 1'b1;
                free_idx = IDX_W'(k);
            end
        end
        for (int k = 0; k < CACHE_ENTRIES; k++) begin
            if (age_rank[k] == IDX_W'(CACHE_ENTRIES - 1)) begin
                lru_idx = IDX_W'(k);
            end
        end
    end

    assign fill_idx = has_free ? free_idx : ((USE_LRU != 0) ? lru_idx : rr_ptr);

    always_comb begin
        if (cache_hit) begin
            result      = LOOKUP_CACHE_HIT;
            result_data = cache_data[hit_idx];
        end else if (match_found) begin
            result      = LOOKUP_QUEUE_MATCH;
            result_data = match_data;
        end else begin
            result      = LOOKUP_HEAD_ONLY;
            result_data = head_data;
        end
    end

    assign fill_en   = pop && (result == LOOKUP_QUEUE_MATCH);
    assign touch_en  = pop && (cache_hit || match_found);
    assign touch_idx = cache_hit ? hit_idx : fill_idx;

    always_ff @(posedge clk) begin
        if (fill_en) begin
            cache_tag[fill_idx]  <= rd_tag;
            cache_data[fill_idx] <= match_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cache_valid <= '0;
            rr_ptr      <= '0;
        end else if (fill_en) begin
            cache_valid[fill_idx] <= 1'b1;
            // Pointer only moves when it picked the victim
            if (!has_free && USE_LRU == 0) begin
                rr_ptr <= (rr_ptr == IDX_W'(CACHE_ENTRIES - 1)) ? '0 : rr_ptr + 1'b1;
            end
        end
    end

    // Touched entry goes to rank 0, younger entries age by one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < CACHE_ENTRIES; k++) begin
                age_rank[k] <= IDX_W'(k);
            end
        end else if (USE_LRU != 0 && touch_en) begin
            for (int k = 0; k < CACHE_ENTRIES; k++) begin
                if (IDX_W'(k) == touch_idx) begin
                    age_rank[k] <= '0;
                end else if (age_rank[k] < age_rank[touch_idx]) begin
                    age_rank[k] <= age_rank[k] + 1'b1;
                end
            end
        end
    end

    // Fill only happens on a cache miss, so a tag never lands twice
    a_single_hit: assert property (
        @(posedge clk) disable iff (!rst_n)
        $onehot0(hit_vec)
    );

    if (USE_LRU != 0) begin : g_rank_check
        for (genvar i = 0; i < CACHE_ENTRIES; i++) begin : g_outer
            for (genvar j = i + 1; j < CACHE_ENTRIES; j++) begin : g_inner
                a_rank_distinct: assert property (
                    @(posedge clk) disable iff (!rst_n)
                    age_rank[i] != age_rank[j]
                );
            end
        end
    end

endmodule

/* hdl/tag_cache_pkg.sv */
// Lookup outcome type and statistics constants for the tagged cache queue
package tag_cache_pkg;

    // Outcome of one accepted read
    typedef enum logic [1:0] {
        // Tag found in the cache
        LOOKUP_CACHE_HIT   = 2'd0,
        // Tag found in the queue, entry copied into the cache
        LOOKUP_QUEUE_MATCH = 2'd1,
        // No match anywhere, head word returned
        LOOKUP_HEAD_ONLY   = 2'd2
    } lookup_result_e;

    // Width of the hit and miss counters and of the ratio
    localparam int STAT_WIDTH = 32;

    // Full-scale hit ratio, 10000 means 100.00 percent
    localparam int RATIO_SCALE = 10000;

endpackage

/* hdl/tag_store_fifo.sv */
// Tag store queue with data and tag memories, status levels and oldest-first tag search
`timescale 1ns/1ps

module tag_store_fifo #(
    parameter int DATA_WIDTH = 32,
    parameter int TAG_WIDTH  = 8,
    parameter int ADDR_WIDTH = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  wr_en,
    input  logic [DATA_WIDTH-1:0] wr_data,
    input  logic [TAG_WIDTH-1:0]  wr_tag,
    input  logic                  rd_en,
    input  logic [TAG_WIDTH-1:0]  rd_tag,
    output logic                  wr_ready,
    output logic                  full,
    output logic                  empty,
    output logic                  rd_valid,
    output logic [ADDR_WIDTH:0]   data_count,
    output logic                  pop,
    output logic                  match_found,
    output logic [DATA_WIDTH-1:0] match_data,
    output logic [DATA_WIDTH-1:0] head_data
);

    localparam int DEPTH = 1 << ADDR_WIDTH;

    logic [DATA_WIDTH-1:0] data_mem [DEPTH];
    logic [TAG_WIDTH-1:0]  tag_mem  [DEPTH];

    // Extra top bit tells full from empty
    logic [ADDR_WIDTH:0] wr_ptr;
    logic [ADDR_WIDTH:0] rd_ptr;
    logic                push;

    assign data_count = wr_ptr - rd_ptr;
    assign full       = (data_count == (ADDR_WIDTH + 1)'(DEPTH));
    assign empty      = (data_count == '0);
    assign wr_ready   = !full;
    assign rd_valid   = !empty;

    assign push = wr_en && !full;
    assign pop  = rd_en && !empty;

    assign head_data = data_mem[rd_ptr[ADDR_WIDTH-1:0]];

    always_ff @(posedge clk) begin
        if (push) begin
            data_mem[wr_ptr[ADDR_WIDTH-1:0]] <= wr_data;
            tag_mem[wr_ptr[ADDR_WIDTH-1:0]]  <= wr_tag;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Walk from the head towards the tail, first equal tag wins
    always_comb begin : tag_search
        logic [ADDR_WIDTH-1:0] addr;
        match_found = 1'b0;
        match_data  = '0;
        for (int i = 0; i < DEPTH; i++) begin
            addr = rd_ptr[ADDR_WIDTH-1:0] + i[ADDR_WIDTH-1:0];
            if (!match_found && (i < int'(data_count)) && (tag_mem[addr] == rd_tag)) begin
                match_found = 1'b1;
                match_data  = data_mem[addr];
            end
        end
    end

    a_count_in_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        data_count <= (ADDR_WIDTH + 1)'(DEPTH)
    );

    // Rejected requests leave the pointers where they were
    a_wr_ptr_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        !push |=> $stable(wr_ptr)
    );

    a_rd_ptr_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        !pop |=> $stable(rd_ptr)
    );

endmodule

/* tag_cache_fifo.f */
+incdir+verification
hdl/tag_cache_pkg.sv
hdl/tag_store_fifo.sv
hdl/tag_cache_lookup.sv
hdl/read_result_stats.sv
hdl/tag_cache_fifo_top.sv
verification/tag_cache_fifo_tb.sv

/* verification/tag_cache_model.svh */
// Reference model of the tag queue, the tag cache with its replacement, and the statistics
`ifndef TAG_CACHE_MODEL_SVH
`define TAG_CACHE_MODEL_SVH

logic [DATA_WIDTH-1:0] q_data [$];
logic [TAG_WIDTH-1:0]  q_tag  [$];
logic [TAG_WIDTH-1:0]  c_tag  [CACHE_N];
logic [DATA_WIDTH-1:0] c_data [CACHE_N];
bit                    c_valid [CACHE_N];
int                    c_rank [CACHE_N];
int                    rr_next;
longint                hits_m;
longint                misses_m;
// Registered outputs expected after the edge just modeled
bit                    exp_done;
logic [DATA_WIDTH-1:0] exp_data;
bit                    exp_hit;
// Index 0 cache hit, 1 queue match, 2 head only
int                    outcome_seen [3];

function automatic void reset_model();
    q_data.delete();
    q_tag.delete();
    for (int k = 0; k < CACHE_N; k++) begin
        c_valid[k] = 1'b0;
        c_rank[k]  = k;
        c_tag[k]   = '0;
        c_data[k]  = '0;
    end
    rr_next  = 0;
    hits_m   = 0;
    misses_m = 0;
    exp_done = 1'b0;
    exp_data = '0;
    exp_hit  = 1'b0;
    for (int k = 0; k < 3; k++) begin
        outcome_seen[k] = 0;
    end
endfunction

// Most recent slot gets rank 0, those younger than it age by one
function automatic void touch_slot(input int slot);
    int old_rank;
    if (USE_LRU == 0) begin
        return;
    end
    old_rank = c_rank[slot];
    for (int k = 0; k < CACHE_N; k++) begin
        if (k == slot) begin
            c_rank[k] = 0;
        end else if (c_rank[k] < old_rank) begin
            c_rank[k] = c_rank[k] + 1;
        end
    end
endfunction

function automatic int choose_slot();
    int victim;
    victim = 0;
    for (int k = 0; k < CACHE_N; k++) begin
        if (!c_valid[k]) begin
            return k;
        end
    end
    if (USE_LRU != 0) begin
        for (int k = 0; k < CACHE_N; k++) begin
            if (c_rank[k] == CACHE_N - 1) begin
                victim = k;
            end
        end
        return victim;
    end
    victim  = rr_next;
    rr_next = (rr_next + 1) % CACHE_N;
    return victim;
endfunction

// One clock edge: the read sees the queue before the same-edge write
function automatic void advance_model(input bit we, input logic [DATA_WIDTH-1:0] wd,
                                      input logic [TAG_WIDTH-1:0] wt, input bit re,
                                      input logic [TAG_WIDTH-1:0] rt, input bit clr);
    bit do_write;
    bit do_read;
    int cache_idx;
    int queue_idx;
    int slot;
    do_write  = we && (q_data.size() < DEPTH);
    do_read   = re && (q_data.size() > 0);
    exp_done  = do_read;
    cache_idx = -1;
    queue_idx = -1;
    if (do_read) begin
        for (int k = 0; k < CACHE_N; k++) begin
            if (c_valid[k] && c_tag[k] == rt) begin
                cache_idx = k;
            end
        end
        if (cache_idx >= 0) begin
            exp_data = c_data[cache_idx];
            exp_hit  = 1'b1;
            touch_slot(cache_idx);
            outcome_seen[0]++;
        end else begin
            exp_hit  = 1'b0;
            exp_data = q_data[0];
            for (int i = q_data.size() - 1; i >= 0; i--) begin
                if (q_tag[i] == rt) begin
                    queue_idx = i;
                end
            end
            if (queue_idx >= 0) begin
                exp_data       = q_data[queue_idx];
                slot           = choose_slot();
                c_valid[slot]  = 1'b1;
                c_tag[slot]    = rt;
                c_data[slot]   = exp_data;
                touch_slot(slot);
                outcome_seen[1]++;
            end else begin
                outcome_seen[2]++;
            end
        end
        void'(q_data.pop_front());
        void'(q_tag.pop_front());
    end
    if (clr) begin
        hits_m   = 0;
        misses_m = 0;
    end else if (do_read) begin
        if (exp_hit) begin
            hits_m++;
        end else begin
            misses_m++;
        end
    end
    if (do_write) begin
        q_data.push_back(wd);
        q_tag.push_back(wt);
    end
endfunction

function automatic longint expected_ratio();
    if (hits_m + misses_m == 0) begin
        return 0;
    end
    return (hits_m * RATIO_SCALE) / (hits_m + misses_m);
endfunction

`endif

/* verification/tag_cache_fifo_tb.sv */
// Testbench for the tagged cache queue: clock, reset, seeded random stimulus, model checks
`timescale 1ns/1ps

module tag_cache_fifo_tb
    import tag_cache_pkg::*;
();

    localparam int CLK_PERIOD    = 40;
    localparam int DATA_WIDTH    = 32;
    localparam int TAG_WIDTH     = 8;
    localparam int ADDR_WIDTH    = 4;
    localparam int DEPTH         = 1 << ADDR_WIDTH;
    localparam int CACHE_N       = 4;
    localparam int USE_LRU       = 1;
    localparam int TAG_BASE      = 8'h30;
    localparam int NUM_TAGS      = 6;
    localparam int FILL_CYCLES   = DEPTH + 4;
    localparam int DRAIN_CYCLES  = DEPTH + 4;
    localparam int RANDOM_CYCLES = 600;
    localparam int CLEAR_CYCLES  = 6;
    localparam int TOTAL_CYCLES  = 2 + FILL_CYCLES + DRAIN_CYCLES + RANDOM_CYCLES
                                   + CLEAR_CYCLES + 2;
    localparam longint WATCHDOG_TIME = longint'(TOTAL_CYCLES + 20) * CLK_PERIOD;

    logic                  clk;
    logic                  rst_n;
    logic                  wr_en;
    logic [DATA_WIDTH-1:0] wr_data;
    logic [TAG_WIDTH-1:0]  wr_tag;
    logic                  rd_en;
    logic [TAG_WIDTH-1:0]  rd_tag;
    logic                  clear_stats;
    logic                  wr_ready;
    logic                  full;
    logic                  empty;
    logic                  rd_valid;
    logic [ADDR_WIDTH:0]   data_count;
    logic [DATA_WIDTH-1:0] rd_data;
    logic                  rd_hit;
    logic                  rd_done;
    logic [STAT_WIDTH-1:0] cache_hits;
    logic [STAT_WIDTH-1:0] cache_misses;
    logic [STAT_WIDTH-1:0] hit_ratio;

    integer seed;
    string  test_name;

    `include "tag_cache_model.svh"

    tag_cache_fifo_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .wr_tag       (wr_tag),
        .rd_en        (rd_en),
        .rd_tag       (rd_tag),
        .clear_stats  (clear_stats),
        .wr_ready     (wr_ready),
        .full         (full),
        .empty        (empty),
        .rd_valid     (rd_valid),
        .data_count   (data_count),
        .rd_data      (rd_data),
        .rd_hit       (rd_hit),
        .rd_done      (rd_done),
        .cache_hits   (cache_hits),
        .cache_misses (cache_misses),
        .hit_ratio    (hit_ratio)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin : watchdog
        #(WATCHDOG_TIME);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_TIME);
        $display("Errors found");
        $fatal(1, "Simulation stopped by the watchdog");
    end

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("Error: test %s, %s expected %0h actual %0h",
                     test_name, what, expected, actual);
            $display("Errors found");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    function automatic logic [TAG_WIDTH-1:0] random_tag();
        int r;
        r = $random(seed);
        return TAG_WIDTH'(TAG_BASE + (r & 32'h7fff_ffff) % NUM_TAGS);
    endfunction

    // True about once in every n calls
    function automatic bit random_chance(input int n);
        int r;
        r = $random(seed);
        return ((r & 32'h7fff_ffff) % n) == 0;
    endfunction

    task automatic check_outputs();
        check_value("data_count", q_data.size(), data_count);
        check_value("full", q_data.size() == DEPTH, full);
        check_value("empty", q_data.size() == 0, empty);
        check_value("rd_valid", q_data.size() != 0, rd_valid);
        check_value("wr_ready", q_data.size() != DEPTH, wr_ready);
        check_value("rd_done", exp_done, rd_done);
        check_value("rd_data", exp_data, rd_data);
        check_value("rd_hit", exp_hit, rd_hit);
        check_value("cache_hits", hits_m, cache_hits);
        check_value("cache_misses", misses_m, cache_misses);
        check_value("hit_ratio", expected_ratio(), hit_ratio);
    endtask

    // Drive on the rising edge, check mid-cycle, then model the next edge
    task automatic run_cycle(input bit we, input logic [DATA_WIDTH-1:0] wd,
                             input logic [TAG_WIDTH-1:0] wt, input bit re,
                             input logic [TAG_WIDTH-1:0] rt, input bit clr);
        @(posedge clk);
        wr_en       <= we;
        wr_data     <= wd;
        wr_tag      <= wt;
        rd_en       <= re;
        rd_tag      <= rt;
        clear_stats <= clr;
        @(negedge clk);
        check_outputs();
        advance_model(we, wd, wt, re, rt, clr);
    endtask

    initial begin : stimulus
        seed        = 32'h5cd6;
        test_name   = "reset";
        rst_n       <= 1'b0;
        wr_en       <= 1'b0;
        wr_data     <= '0;
        wr_tag      <= '0;
        rd_en       <= 1'b0;
        rd_tag      <= '0;
        clear_stats <= 1'b0;
        reset_model();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_value("rd_done after reset", 0, rd_done);
        check_value("empty after reset", 1, empty);
        check_value("cache_hits after reset", 0, cache_hits);
        check_value("cache_misses after reset", 0, cache_misses);
        check_value("hit_ratio after reset", 0, hit_ratio);

        // Some writes land while the queue is full
        test_name = "fill";
        repeat (FILL_CYCLES) run_cycle(1'b1, $random(seed), random_tag(), 1'b0, '0, 1'b0);

        // Some reads land while the queue is empty
        test_name = "drain";
        repeat (DRAIN_CYCLES) run_cycle(1'b0, '0, '0, 1'b1, random_tag(), 1'b0);

        test_name = "random_mix";
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            if (n < RANDOM_CYCLES / 2) begin
                run_cycle(!random_chance(3), $random(seed), random_tag(),
                          random_chance(2), random_tag(), random_chance(50));
            end else begin
                run_cycle(random_chance(2), $random(seed), random_tag(),
                          !random_chance(3), random_tag(), random_chance(50));
            end
        end

        test_name = "clear";
        run_cycle(1'b1, $random(seed), random_tag(), 1'b0, '0, 1'b0);
        run_cycle(1'b1, $random(seed), random_tag(), 1'b0, '0, 1'b0);
        run_cycle(1'b0, '0, '0, 1'b1, random_tag(), 1'b1);
        run_cycle(1'b0, '0, '0, 1'b0, '0, 1'b0);
        check_value("cache_hits after clear with read", 0, cache_hits);
        check_value("cache_misses after clear with read", 0, cache_misses);
        check_value("hit_ratio after clear with read", 0, hit_ratio);
        run_cycle(1'b0, '0, '0, 1'b0, '0, 1'b1);
        run_cycle(1'b0, '0, '0, 1'b0, '0, 1'b0);

        test_name = "coverage";
        run_cycle(1'b0, '0, '0, 1'b0, '0, 1'b0);
        check_value("cache hit outcome seen", 1, outcome_seen[0] > 0);
        check_value("queue match outcome seen", 1, outcome_seen[1] > 0);
        check_value("head only outcome seen", 1, outcome_seen[2] > 0);

        $display("No errors");
        $finish;
    end

endmodule
